// File: butterfly.sv
module butterfly (
    input  logic          clk,
    input  logic          rst_n,
    input  nttPkg::coef_t lo,
    input  nttPkg::coef_t hi,
    input  nttPkg::coef_t zeta,
    output nttPkg::coef_t bfLo,
    output nttPkg::coef_t bfHi
);

    nttPkg::coef_t          t;
    logic [nttPkg::CoefW:0] sum;
    logic [nttPkg::CoefW:0] diff;
    logic [nttPkg::CoefW:0] sumFix;
    logic [nttPkg::CoefW:0] diffFix;

    modMul i_modMul (
        .a       (zeta),
        .b       (hi),
        .product (t)
    );

    assign sum = {1'b0, lo} + {1'b0, t};
    // Add Q first so the difference stays positive
    assign diff = {1'b0, lo} + {1'b0, nttPkg::Q} - {1'b0, t};
    assign sumFix = (sum >= nttPkg::Q) ? sum - nttPkg::Q : sum;
    assign diffFix = (diff >= nttPkg::Q) ? diff - nttPkg::Q : diff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bfLo <= '0;
            bfHi <= '0;
        end else begin
            bfLo <= sumFix[nttPkg::CoefW-1:0];
            bfHi <= diffFix[nttPkg::CoefW-1:0];
        end
    end

endmodule

// File: coefBank.sv
module coefBank (
    input  logic          clk,
    input  nttPkg::idx_t  rdAddrLo,
    input  nttPkg::idx_t  rdAddrHi,
    input  logic          wrEnLo,
    input  logic          wrEnHi,
    input  nttPkg::idx_t  wrAddrLo,
    input  nttPkg::idx_t  wrAddrHi,
    input  nttPkg::coef_t wrDataLo,
    input  nttPkg::coef_t wrDataHi,
    output nttPkg::coef_t rdDataLo,
    output nttPkg::coef_t rdDataHi
);

    nttPkg::coef_t mem [nttPkg::N];

    always_ff @(posedge clk) begin
        if (wrEnLo) begin
            mem[wrAddrLo] <= wrDataLo;
        end
        if (wrEnHi) begin
            mem[wrAddrHi] <= wrDataHi;
        end
    end

    // Reads are combinational, same cycle as the address
    assign rdDataLo = mem[rdAddrLo];
    assign rdDataHi = mem[rdAddrHi];

    noWriteCollision: assert property (@(posedge clk)
        (wrEnLo && wrEnHi) |-> (wrAddrLo != wrAddrHi));

endmodule

// File: filelist.f
nttPkg.sv
modMul.sv
butterfly.sv
twiddleGen.sv
coefBank.sv
nttCtrl.sv
nttTop.sv
nttTb.sv

// File: modMul.sv
module modMul (
    input  nttPkg::coef_t a,
    input  nttPkg::coef_t b,
    output nttPkg::coef_t product
);

    logic [nttPkg::ProdW-1:0]            full;
    logic [nttPkg::ProdW+nttPkg::CoefW:0] scaled;
    logic [nttPkg::CoefW-1:0]            quot;
    logic [nttPkg::ProdW-1:0]            quotTimesQ;
    logic [nttPkg::CoefW+1:0]            rem;
    logic [nttPkg::CoefW+1:0]            remFix;
    logic [nttPkg::CoefW+1:0]            remOut;

    assign full = a * b;

    // Quotient estimate, low by at most two
    assign scaled = full * nttPkg::BarrettMu;
    assign quot = scaled[nttPkg::BarrettK +: nttPkg::CoefW];
    assign quotTimesQ = quot * nttPkg::Q;

    // Remainder is below 3Q so 25 bits hold it
    assign rem = full[nttPkg::CoefW+1:0] - quotTimesQ[nttPkg::CoefW+1:0];
    assign remFix = (rem >= nttPkg::Q) ? rem - nttPkg::Q : rem;
    assign remOut = (remFix >= nttPkg::Q) ? remFix - nttPkg::Q : remFix;
    assign product = remOut[nttPkg::CoefW-1:0];

    productReduced: assert final ($isunknown({a, b}) || (product < nttPkg::Q));

endmodule

// File: nttCtrl.sv
module nttCtrl (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  nttPkg::coef_t coefIn,
    input  nttPkg::coef_t zeta,
    input  logic          zetaValid,
    input  nttPkg::coef_t bfHi,
    input  nttPkg::coef_t bfLo,
    output nttPkg::idx_t  rdAddrLo,
    output nttPkg::idx_t  rdAddrHi,
    output logic          wrEnLo,
    output logic          wrEnHi,
    output nttPkg::idx_t  wrAddrLo,
    output nttPkg::idx_t  wrAddrHi,
    output nttPkg::coef_t wrDataLo,
    output nttPkg::coef_t wrDataHi,
    output logic          zetaReq,
    output nttPkg::idx_t  zetaIdx,
    output logic          busy,
    output logic          done,
    output logic          coefOutValid
);

    nttPkg::nttState_e state;
    nttPkg::lenIdx_t   cnt;
    nttPkg::lenIdx_t   len;
    nttPkg::lenIdx_t   groupStart;
    nttPkg::lenIdx_t   j;
    nttPkg::lenIdx_t   m;
    nttPkg::lenIdx_t   hiIdx;
    nttPkg::lenIdx_t   lastJ;
    nttPkg::lenIdx_t   nextGroup;

    assign hiIdx = j + len;
    assign lastJ = groupStart + len - 9'd1;
    assign nextGroup = groupStart + (len << 1);

    // Bank addressing, load and store share port 0
    assign rdAddrLo = (state == nttPkg::Store) ? cnt[nttPkg::LogN-1:0] : j[nttPkg::LogN-1:0];
    assign rdAddrHi = hiIdx[nttPkg::LogN-1:0];
    assign wrEnLo = (state == nttPkg::Load) || (state == nttPkg::ButterflyWrite);
    assign wrEnHi = (state == nttPkg::ButterflyWrite);
    assign wrAddrLo = (state == nttPkg::Load) ? cnt[nttPkg::LogN-1:0] : j[nttPkg::LogN-1:0];
    assign wrAddrHi = hiIdx[nttPkg::LogN-1:0];
    assign wrDataLo = (state == nttPkg::Load) ? coefIn : bfLo;
    assign wrDataHi = bfHi;

    assign zetaReq = (state == nttPkg::GroupStart);
    assign zetaIdx = m[nttPkg::LogN-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= nttPkg::Idle;
            cnt <= '0;
            len <= '0;
            groupStart <= '0;
            j <= '0;
            m <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            coefOutValid <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                // Done behaves like Idle, busy is already low there
                nttPkg::Idle, nttPkg::Done: begin
                    state <= nttPkg::Idle;
                    if (start) begin
                        state <= nttPkg::Load;
                        busy <= 1'b1;
                        cnt <= '0;
                        len <= nttPkg::lenIdx_t'(nttPkg::N);
                        m <= 9'd1;
                    end
                end
                nttPkg::Load: begin
                    cnt <= cnt + 9'd1;
                    if (cnt == nttPkg::N - 1) begin
                        state <= nttPkg::LenLoop;
                    end
                end
                nttPkg::LenLoop: begin
                    len <= len >> 1;
                    groupStart <= '0;
                    if ((len >> 1) == '0) begin
                        state <= nttPkg::Store;
                        cnt <= '0;
                        coefOutValid <= 1'b1;
                    end else begin
                        state <= nttPkg::GroupStart;
                    end
                end
                nttPkg::GroupStart: begin
                    m <= m + 9'd1;
                    j <= groupStart;
                    state <= nttPkg::ZetaWait;
                end
                nttPkg::ZetaWait: begin
                    if (zetaValid) begin
                        state <= nttPkg::ButterflyRead;
                    end
                end
                nttPkg::ButterflyRead: begin
                    state <= nttPkg::ButterflyWrite;
                end
                nttPkg::ButterflyWrite: begin
                    if (j == lastJ) begin
                        groupStart <= nextGroup;
                        state <= (nextGroup == nttPkg::N) ? nttPkg::LenLoop
                                                          : nttPkg::GroupStart;
                    end else begin
                        j <= j + 9'd1;
                        state <= nttPkg::ButterflyRead;
                    end
                end
                nttPkg::Store: begin
                    cnt <= cnt + 9'd1;
                    if (cnt == nttPkg::N - 1) begin
                        state <= nttPkg::Done;
                        coefOutValid <= 1'b0;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
                default: state <= nttPkg::Idle;
            endcase
        end
    end

    zetaReqNoOverlap: assert property (@(posedge clk) disable iff (!rst_n)
        zetaReq |=> (!zetaReq until zetaValid));

    validOnlyInStore: assert property (@(posedge clk) disable iff (!rst_n)
        coefOutValid |-> state == nttPkg::Store);

    // 255 groups per transform, so m stays in 1..N-1
    zetaIdxInRange: assert property (@(posedge clk) disable iff (!rst_n)
        zetaReq |-> (m != '0) && (m <= nttPkg::N - 1));

    zetaHeldInGroup: assert property (@(posedge clk) disable iff (!rst_n)
        (state == nttPkg::ButterflyRead) && ($past(state) == nttPkg::ButterflyWrite)
        |-> $stable(zeta));

endmodule

// File: nttPkg.sv
package nttPkg;

    // Field parameters
    localparam logic [22:0] Q = 23'd8380417;
    localparam int CoefW = 23;
    localparam int ProdW = 46;
    localparam int N = 256;
    localparam int LogN = 8;

    // Primitive 512th root of unity mod Q
    localparam logic [22:0] RootOfUnity = 23'd1753;

    // Barrett constants, Mu = floor(2^46 / Q)
    localparam int BarrettK = 46;
    localparam logic [23:0] BarrettMu = 24'd8396807;

    typedef logic [CoefW-1:0] coef_t;
    typedef logic [LogN-1:0] idx_t;
    typedef logic [LogN:0] lenIdx_t;

    typedef enum logic [3:0] {
        Idle,
        Load,
        LenLoop,
        GroupStart,
        ZetaWait,
        ButterflyRead,
        ButterflyWrite,
        Store,
        Done
    } nttState_e;

endpackage

// File: nttTb.sv
module nttTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod = 40;
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 8;
    localparam int NumRuns = 7;
    localparam int CyclesPerRun = nttPkg::N * 40;
    localparam int WatchdogCycles = NumRuns * CyclesPerRun + ResetCycles + 100;

    logic          clk;
    logic          rst_n;
    logic          start;
    nttPkg::coef_t coefIn;
    nttPkg::coef_t coefOut;
    logic          coefOutValid;
    logic          busy;
    logic          done;

    nttPkg::coef_t stimVec [nttPkg::N];
    nttPkg::coef_t expVec [nttPkg::N];
    string         testName;
    int            outIdx;
    int            doneCount;
    logic          lastValid;
    logic [31:0]   lfsrState;

    nttTop i_nttTop (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .coefIn       (coefIn),
        .coefOut      (coefOut),
        .coefOutValid (coefOutValid),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            reportFailure($sformatf("mismatch %s: expected %0d, actual %0d",
                                    name, expected, actual));
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic nttPkg::coef_t randCoef();
        nttPkg::coef_t value;
        int b;
        do begin
            for (b = 0; b < nttPkg::CoefW; b++) begin
                value[b] = lfsrBit();
            end
        end while (value >= nttPkg::Q);
        return value;
    endfunction

    // Root raised to the 8-bit reversal of m
    function automatic longint zetaOf(input int m);
        int rev;
        int b;
        int k;
        longint z;
        rev = 0;
        for (b = 0; b < nttPkg::LogN; b++) begin
            if (((m >> b) & 1) == 1) begin
                rev = rev | (1 << (nttPkg::LogN - 1 - b));
            end
        end
        z = 1;
        for (k = 0; k < rev; k++) begin
            z = (z * longint'(nttPkg::RootOfUnity)) % longint'(nttPkg::Q);
        end
        return z;
    endfunction

    function automatic void nttRef(input nttPkg::coef_t inVec [nttPkg::N],
                                   output nttPkg::coef_t outVec [nttPkg::N]);
        longint a [nttPkg::N];
        longint q;
        longint z;
        longint t;
        int len;
        int st;
        int j;
        int m;
        q = longint'(nttPkg::Q);
        for (j = 0; j < nttPkg::N; j++) begin
            a[j] = longint'(inVec[j]);
        end
        m = 0;
        for (len = nttPkg::N / 2; len > 0; len = len / 2) begin
            for (st = 0; st < nttPkg::N; st = st + 2 * len) begin
                m++;
                z = zetaOf(m);
                for (j = st; j < st + len; j++) begin
                    t = (z * a[j + len]) % q;
                    a[j + len] = (a[j] - t + q) % q;
                    a[j] = (a[j] + t) % q;
                end
            end
        end
        for (j = 0; j < nttPkg::N; j++) begin
            outVec[j] = nttPkg::coef_t'(a[j]);
        end
    endfunction

    // Output stream compare at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (coefOutValid) begin
                if (outIdx >= nttPkg::N) begin
                    reportFailure($sformatf("%s: more than %0d output cycles",
                                            testName, nttPkg::N));
                end else if ((outIdx != 0) && !lastValid) begin
                    reportFailure($sformatf("%s: gap in the output stream before coef %0d",
                                            testName, outIdx));
                end else begin
                    checkValue($sformatf("%s coef %0d", testName, outIdx),
                               expVec[outIdx], coefOut);
                    outIdx++;
                end
            end
            if (done) begin
                if (!lastValid || coefOutValid) begin
                    reportFailure($sformatf("%s: done did not follow the last output",
                                            testName));
                end
                checkValue($sformatf("%s busy with done", testName), 0, busy);
                doneCount++;
            end
            lastValid = coefOutValid;
        end
    end

    task automatic runTransform(input string name, input bit pulseWhileBusy);
        int i;
        testName = name;
        outIdx = 0;
        doneCount = 0;
        start = 1'b1;
        @(posedge clk);
        #(DriveDelay);
        start = 1'b0;
        checkValue($sformatf("%s busy after start", name), 1, busy);
        for (i = 0; i < nttPkg::N; i++) begin
            coefIn = stimVec[i];
            @(posedge clk);
            #(DriveDelay);
        end
        coefIn = '0;
        if (pulseWhileBusy) begin
            repeat (300) @(posedge clk);
            #(DriveDelay);
            checkValue($sformatf("%s busy before extra start", name), 1, busy);
            start = 1'b1;
            @(posedge clk);
            #(DriveDelay);
            start = 1'b0;
        end
        while (doneCount == 0) begin
            @(posedge clk);
        end
        #(DriveDelay);
        if (outIdx != nttPkg::N) begin
            reportFailure($sformatf("%s: %0d output cycles instead of %0d",
                                    name, outIdx, nttPkg::N));
        end
        checkValue($sformatf("%s busy after done", name), 0, busy);
        @(posedge clk);
        #(DriveDelay);
        if (doneCount != 1) begin
            reportFailure($sformatf("%s: done was high for more than one cycle", name));
        end
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        reportFailure("timeout: the DUT never signalled done within the time budget");
    end

    initial begin
        int i;
        int r;
        rst_n = 1'b0;
        start = 1'b0;
        coefIn = '0;
        outIdx = 0;
        doneCount = 0;
        lastValid = 1'b0;
        testName = "reset";
        lfsrState = 32'd93773;
        repeat (ResetCycles) @(posedge clk);
        #(DriveDelay);
        rst_n = 1'b1;

        // Nothing moves before the first start
        repeat (10) begin
            @(posedge clk);
            #(DriveDelay);
            checkValue("idle busy", 0, busy);
            checkValue("idle done", 0, done);
            checkValue("idle coefOutValid", 0, coefOutValid);
        end

        for (i = 0; i < nttPkg::N; i++) begin
            stimVec[i] = '0;
            expVec[i] = '0;
        end
        runTransform("zero input", 1'b0);

        // Impulse transforms to all ones
        stimVec[0] = nttPkg::coef_t'(1);
        for (i = 0; i < nttPkg::N; i++) begin
            expVec[i] = nttPkg::coef_t'(1);
        end
        runTransform("impulse", 1'b0);

        for (r = 0; r < 3; r++) begin
            for (i = 0; i < nttPkg::N; i++) begin
                stimVec[i] = randCoef();
            end
            nttRef(stimVec, expVec);
            runTransform($sformatf("random %0d", r), 1'b0);
        end

        for (i = 0; i < nttPkg::N; i++) begin
            stimVec[i] = nttPkg::Q - 23'd1;
        end
        nttRef(stimVec, expVec);
        runTransform("all q minus one", 1'b0);

        for (i = 0; i < nttPkg::N; i++) begin
            stimVec[i] = randCoef();
        end
        nttRef(stimVec, expVec);
        runTransform("start while busy", 1'b1);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: nttTop.sv
module nttTop (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  nttPkg::coef_t coefIn,
    output nttPkg::coef_t coefOut,
    output logic          coefOutValid,
    output logic          busy,
    output logic          done
);

    nttPkg::idx_t  rdAddrLo;
    nttPkg::idx_t  rdAddrHi;
    nttPkg::idx_t  wrAddrLo;
    nttPkg::idx_t  wrAddrHi;
    nttPkg::idx_t  zetaIdx;
    logic          wrEnLo;
    logic          wrEnHi;
    logic          zetaReq;
    logic          zetaValid;
    nttPkg::coef_t wrDataLo;
    nttPkg::coef_t wrDataHi;
    nttPkg::coef_t rdDataHi;
    nttPkg::coef_t zeta;
    nttPkg::coef_t bfLo;
    nttPkg::coef_t bfHi;

    nttCtrl i_nttCtrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .coefIn       (coefIn),
        .zeta         (zeta),
        .zetaValid    (zetaValid),
        .bfHi         (bfHi),
        .bfLo         (bfLo),
        .rdAddrLo     (rdAddrLo),
        .rdAddrHi     (rdAddrHi),
        .wrEnLo       (wrEnLo),
        .wrEnHi       (wrEnHi),
        .wrAddrLo     (wrAddrLo),
        .wrAddrHi     (wrAddrHi),
        .wrDataLo     (wrDataLo),
        .wrDataHi     (wrDataHi),
        .zetaReq      (zetaReq),
        .zetaIdx      (zetaIdx),
        .busy         (busy),
        .done         (done),
        .coefOutValid (coefOutValid)
    );

    // Read port 0 serves both the butterfly and the output stream
    coefBank i_coefBank (
        .clk      (clk),
        .rdAddrLo (rdAddrLo),
        .rdAddrHi (rdAddrHi),
        .wrEnLo   (wrEnLo),
        .wrEnHi   (wrEnHi),
        .wrAddrLo (wrAddrLo),
        .wrAddrHi (wrAddrHi),
        .wrDataLo (wrDataLo),
        .wrDataHi (wrDataHi),
        .rdDataLo (coefOut),
        .rdDataHi (rdDataHi)
    );

    twiddleGen i_twiddleGen (
        .clk       (clk),
        .rst_n     (rst_n),
        .zetaReq   (zetaReq),
        .zetaIdx   (zetaIdx),
        .zeta      (zeta),
        .zetaValid (zetaValid)
    );

    butterfly i_butterfly (
        .clk   (clk),
        .rst_n (rst_n),
        .lo    (coefOut),
        .hi    (rdDataHi),
        .zeta  (zeta),
        .bfLo  (bfLo),
        .bfHi  (bfHi)
    );

endmodule

// File: twiddleGen.sv
module twiddleGen (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          zetaReq,
    input  nttPkg::idx_t  zetaIdx,
    output nttPkg::coef_t zeta,
    output logic          zetaValid
);

    nttPkg::idx_t  revIdx;
    nttPkg::idx_t  exponent;
    logic [2:0]    bitsLeft;
    logic          running;
    logic          mulPhase;
    nttPkg::coef_t acc;
    nttPkg::coef_t mulB;
    nttPkg::coef_t mulOut;

    assign revIdx = {<<{zetaIdx}};

    // Square the accumulator, or multiply it by the root on a set bit
    assign mulB = mulPhase ? nttPkg::RootOfUnity : acc;
    assign zeta = acc;

    modMul i_modMul (
        .a       (acc),
        .b       (mulB),
        .product (mulOut)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            mulPhase <= 1'b0;
            exponent <= '0;
            bitsLeft <= '0;
            acc <= '0;
            zetaValid <= 1'b0;
        end else begin
            zetaValid <= 1'b0;
            if (zetaReq) begin
                exponent <= revIdx;
                bitsLeft <= 3'(nttPkg::LogN - 1);
                acc <= nttPkg::coef_t'(1);
                running <= 1'b1;
                mulPhase <= 1'b0;
            end else if (running) begin
                acc <= mulOut;
                if (!mulPhase && exponent[nttPkg::LogN-1]) begin
                    mulPhase <= 1'b1;
                end else begin
                    // Bit finished, move to the next lower one
                    mulPhase <= 1'b0;
                    exponent <= exponent << 1;
                    bitsLeft <= bitsLeft - 3'd1;
                    if (bitsLeft == '0) begin
                        running <= 1'b0;
                        zetaValid <= 1'b1;
                    end
                end
            end
        end
    end

endmodule
